/* include/cnn_conv_consts.svh */
`ifndef CNN_CONV_CONSTS_SVH
`define CNN_CONV_CONSTS_SVH

// frame geometry, small test frame
`define IMG_W 8
`define IMG_H 8

// unsigned camera pixel
`define PIX_W 8
// one screen axis, enough for 0..7
`define COORD_W 3

// signed kernel weight
`define WEIGHT_W 4
// signed tree sum, headroom for 9 taps
`define SUM_W 17
// rectified feature pixel
`define FM_W 16

// kernel count and size
`define NUM_KERNELS 4
`define KSIZE 3

// products, row sums, total plus relu
`define MA_STAGES 3

// weight table, kernel 0 in the top nibbles
// each kernel row-major, top-left weight first
// k0 horizontal edge   -1 -2 -1 /  0 0  0 /  1  2  1
// k1 vertical edge     -1  0  1 / -2 0  2 / -1  0  1
// k2 sharpen            0 -1  0 / -1 5 -1 /  0 -1  0
// k3 box sum            1  1  1 /  1 1  1 /  1  1  1
`define KERNEL_WEIGHTS 144'hFEF000121_F01E02F01_0F0F5F0F0_111111111

`endif

/* design/cnn_video_pkg.sv */
`include "cnn_conv_consts.svh"

// video side types: what the camera delivers
package cnn_video_pkg;

  // raw camera pixel, unsigned
  typedef logic [`PIX_W-1:0] pixel_t;

  // screen position of a pixel
  typedef struct packed {
    logic [`COORD_W-1:0] x;
    logic [`COORD_W-1:0] y;
  } coord_t;

  // one raster beat, pixel plus where it sits
  typedef struct packed {
    pixel_t pixel;
    coord_t coord;
  } pix_beat_t;

  // 3x3 neighbourhood, row-major
  // px[8] is top-left, px[0] bottom-right (newest pixel)
  typedef struct packed {
    pixel_t [`KSIZE*`KSIZE-1:0] px;
  } window_t;

endpackage

/* design/cnn_conv_pkg.sv */
`include "cnn_conv_consts.svh"

// convolution side types: weights and results
package cnn_conv_pkg;

  // one signed tap weight
  typedef logic signed [`WEIGHT_W-1:0] weight_t;

  // nine taps, same index order as window_t px
  // so w[8] pairs with the top-left pixel
  typedef weight_t [`KSIZE*`KSIZE-1:0] kernel_t;

  // full precision tree sum
  typedef logic signed [`SUM_W-1:0] sum_t;

  // rectified output, never negative
  typedef logic [`FM_W-1:0] fm_pixel_t;

  // one feature beat across all kernels
  // coord is the bottom-right corner of the window
  typedef struct packed {
    fm_pixel_t [`NUM_KERNELS-1:0] fm;
    cnn_video_pkg::coord_t        coord;
  } fm_beat_t;

endpackage

/* design/window_buffer.sv */
`timescale 1ns/1ps
`include "cnn_conv_consts.svh"

module window_buffer (
  input  logic                     clock,
  input  logic                     arst_n,
  input  logic                     pixel_valid,
  input  cnn_video_pkg::pix_beat_t pixel_in,
  output cnn_video_pkg::window_t   win,
  output logic                     win_valid,
  output cnn_video_pkg::coord_t    win_coord
);

  // first x / y where a full window exists
  localparam logic [`COORD_W-1:0] EDGE = `COORD_W'(`KSIZE - 1);

  // row y-1 and row y-2, indexed by x
  cnn_video_pkg::pixel_t lb_mid [`IMG_W];
  cnn_video_pkg::pixel_t lb_top [`IMG_W];
  // window regs [row][col], row 0 on top
  cnn_video_pkg::pixel_t win_q [`KSIZE][`KSIZE];
  // column entering on the right, top to bottom
  cnn_video_pkg::pixel_t col_new [`KSIZE];
  logic                  win_done;

  ////////////////////////////////////////////////////////////////////////////
  // position decode
  ////////////////////////////////////////////////////////////////////////////

  // window is complete once two rows and two columns lie behind us
  assign win_done = (pixel_in.coord.x >= EDGE) && (pixel_in.coord.y >= EDGE);

  // read the rows above at the current column
  always_comb begin
    col_new[0] = lb_top[pixel_in.coord.x];
    col_new[1] = lb_mid[pixel_in.coord.x];
    col_new[2] = pixel_in.pixel;
  end

  ////////////////////////////////////////////////////////////////////////////
  // line buffers and shift window
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < `IMG_W; i++) begin
        lb_mid[i] <= '0;
        lb_top[i] <= '0;
      end
      for (int r = 0; r < `KSIZE; r++) begin
        for (int c = 0; c < `KSIZE; c++) begin
          win_q[r][c] <= '0;
        end
      end
      win_valid <= 1'b0;
      win_coord <= '0;
    end else begin
      // one-cycle strobe per completed window
      win_valid <= pixel_valid && win_done;
      if (pixel_valid) begin
        // rows move up one line at this column
        lb_mid[pixel_in.coord.x] <= pixel_in.pixel;
        lb_top[pixel_in.coord.x] <= lb_mid[pixel_in.coord.x];
        // window slides left, new column on the right
        for (int r = 0; r < `KSIZE; r++) begin
          for (int c = 0; c < `KSIZE - 1; c++) begin
            win_q[r][c] <= win_q[r][c+1];
          end
          win_q[r][`KSIZE-1] <= col_new[r];
        end
        // bottom-right corner of this window
        win_coord <= pixel_in.coord;
      end
    end
  end

  // flatten into px order, top-left in the top slot
  always_comb begin
    for (int r = 0; r < `KSIZE; r++) begin
      for (int c = 0; c < `KSIZE; c++) begin
        win.px[`KSIZE*`KSIZE-1 - (r*`KSIZE + c)] = win_q[r][c];
      end
    end
  end

endmodule

/* design/mult_adder.sv */
`timescale 1ns/1ps
`include "cnn_conv_consts.svh"

module mult_adder (
  input  logic                    clock,
  input  logic                    arst_n,
  input  cnn_video_pkg::window_t  win,
  input  cnn_conv_pkg::kernel_t   weights,
  output cnn_conv_pkg::fm_pixel_t fm_pixel
);

  localparam int NTAPS = `KSIZE * `KSIZE;

  // stage 1, one product per tap
  cnn_conv_pkg::sum_t prod_q [NTAPS];
  // stage 2, one sum per window row
  cnn_conv_pkg::sum_t row_q [`KSIZE];
  // rows added, before the clip
  cnn_conv_pkg::sum_t total;

  // sum of the three taps of row r
  function automatic cnn_conv_pkg::sum_t row_sum(input int r);
    cnn_conv_pkg::sum_t acc;
    acc = '0;
    for (int c = 0; c < `KSIZE; c++) begin
      acc = acc + prod_q[NTAPS-1 - (r*`KSIZE + c)];
    end
    return acc;
  endfunction

  always_comb begin
    total = '0;
    for (int r = 0; r < `KSIZE; r++) begin
      total = total + row_q[r];
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // three-stage tree
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < NTAPS; i++) begin
        prod_q[i] <= '0;
      end
      for (int r = 0; r < `KSIZE; r++) begin
        row_q[r] <= '0;
      end
      fm_pixel <= '0;
    end else begin
      // pixel is unsigned, zero bit on top before the signed multiply
      for (int i = 0; i < NTAPS; i++) begin
        prod_q[i] <= cnn_conv_pkg::sum_t'($signed({1'b0, win.px[i]}))
                   * cnn_conv_pkg::sum_t'($signed(weights[i]));
      end
      for (int r = 0; r < `KSIZE; r++) begin
        row_q[r] <= row_sum(r);
      end
      // relu, positive sums always fit in FM_W
      fm_pixel <= total[`SUM_W-1] ? '0 : total[`FM_W-1:0];
    end
  end

endmodule

/* design/delay_line.sv */
`timescale 1ns/1ps

module delay_line #(
  parameter type payload_t = logic,
  parameter int  DEPTH     = 3
) (
  input  logic     clock,
  input  logic     arst_n,
  input  payload_t din,
  output payload_t dout
);

  // pipe_q[0] is the newest entry
  payload_t pipe_q [DEPTH];

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < DEPTH; i++) begin
        pipe_q[i] <= '0;
      end
    end else begin
      pipe_q[0] <= din;
      for (int i = 1; i < DEPTH; i++) begin
        pipe_q[i] <= pipe_q[i-1];
      end
    end
  end

  assign dout = pipe_q[DEPTH-1];

endmodule

/* design/conv_top.sv */
`timescale 1ns/1ps
`include "cnn_conv_consts.svh"

module conv_top (
  input  logic                          clock,
  input  logic                          arst_n,
  input  logic                          pixel_valid,
  input  cnn_video_pkg::pix_beat_t      pixel_in,
  output wire                           fm_valid,
  output wire cnn_conv_pkg::fm_beat_t   fm_out
);

  // bits per kernel in the weight table
  localparam int KW_W = `KSIZE * `KSIZE * `WEIGHT_W;
  localparam logic [`NUM_KERNELS*KW_W-1:0] KERNEL_W = `KERNEL_WEIGHTS;

  // window to trees
  cnn_video_pkg::window_t win;
  logic                   win_valid;
  cnn_video_pkg::coord_t  win_coord;

  window_buffer i_window_buffer (
    .clock      (clock),
    .arst_n     (arst_n),
    .pixel_valid(pixel_valid),
    .pixel_in   (pixel_in),
    .win        (win),
    .win_valid  (win_valid),
    .win_coord  (win_coord)
  );

  // one tree per kernel, kernel 0 sits in the top bits of the table
  for (genvar k = 0; k < `NUM_KERNELS; k++) begin : g_tree
    mult_adder i_mult_adder (
      .clock   (clock),
      .arst_n  (arst_n),
      .win     (win),
      .weights (cnn_conv_pkg::kernel_t'(KERNEL_W[(`NUM_KERNELS-1-k)*KW_W +: KW_W])),
      .fm_pixel(fm_out.fm[k])
    );
  end

  // coord and strobe ride beside the trees
  delay_line #(.payload_t(cnn_video_pkg::coord_t), .DEPTH(`MA_STAGES)) i_coord_dly (
    .clock (clock),
    .arst_n(arst_n),
    .din   (win_coord),
    .dout  (fm_out.coord)
  );

  delay_line #(.payload_t(logic), .DEPTH(`MA_STAGES)) i_valid_dly (
    .clock (clock),
    .arst_n(arst_n),
    .din   (win_valid),
    .dout  (fm_valid)
  );

endmodule

/* testbench/tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen (
  output logic clock,
  output logic arst_n
);

  // 8 ns period
  initial begin
    clock = 1'b0;
    forever #4 clock = ~clock;
  end

  // reset held for 16 cycles, released away from the rising edge
  initial begin
    arst_n = 1'b0;
    repeat (16) @(posedge clock);
    @(negedge clock);
    arst_n = 1'b1;
  end

endmodule

/* testbench/conv_checker.sv */
`timescale 1ns/1ps
`include "cnn_conv_consts.svh"

module conv_checker (
  input  logic                   clock,
  input  logic                   arst_n,
  input  logic                   fm_valid,
  input  cnn_conv_pkg::fm_beat_t fm_out,
  output logic                   done,
  output int                     error_count,
  output int                     check_count
);

  localparam int FRAME_PIX = `IMG_W * `IMG_H;
  localparam int NUM_PIX   = 2 * FRAME_PIX;
  // x, y, pixel, then one column per kernel
  localparam int COLS      = 3 + `NUM_KERNELS;

  typedef struct {
    int frame;
    int x;
    int y;
    int fm [`NUM_KERNELS];
  } expect_t;

  logic [15:0] golden [NUM_PIX*COLS];
  expect_t     expect_q [$];
  expect_t     exp_e;
  expect_t     ent;
  int          expected_total;
  int          beats_seen;

  // compare one value, report on mismatch
  task automatic check_value(input string name, input int expected, input int actual);
    check_count++;
    if (expected != actual) begin
      error_count++;
      $display("CHECK FAILED %s expected %0d actual %0d", name, expected, actual);
    end
  endtask

  // expected beats in raster order, only complete windows
  initial begin
    error_count = 0;
    check_count = 0;
    beats_seen  = 0;
    $readmemh("testbench/conv_golden.txt", golden);
    for (int i = 0; i < NUM_PIX; i++) begin
      ent.frame = i / FRAME_PIX;
      ent.x     = int'(golden[i*COLS]);
      ent.y     = int'(golden[i*COLS+1]);
      for (int k = 0; k < `NUM_KERNELS; k++) begin
        ent.fm[k] = int'(golden[i*COLS+3+k]);
      end
      if (ent.x >= `KSIZE - 1 && ent.y >= `KSIZE - 1) begin
        expect_q.push_back(ent);
      end
    end
    expected_total = expect_q.size();
  end

  assign done = (expected_total > 0) && (beats_seen == expected_total);

  // sample mid-cycle, outputs are registered on the rising edge
  always @(negedge clock) begin
    if (arst_n && fm_valid) begin
      if (expect_q.size() == 0) begin
        error_count++;
        $display("ERROR: feature beat at x=%0d y=%0d with no window expected",
                 fm_out.coord.x, fm_out.coord.y);
      end else begin
        exp_e = expect_q.pop_front();
        beats_seen++;
        check_value($sformatf("frame%0d_coord_x", exp_e.frame), exp_e.x,
                    int'(fm_out.coord.x));
        check_value($sformatf("frame%0d_coord_y", exp_e.frame), exp_e.y,
                    int'(fm_out.coord.y));
        for (int k = 0; k < `NUM_KERNELS; k++) begin
          check_value($sformatf("frame%0d_k%0d_at_%0d_%0d", exp_e.frame, k, exp_e.x, exp_e.y),
                      exp_e.fm[k], int'(fm_out.fm[k]));
        end
      end
    end
  end

endmodule

/* testbench/conv_assertions.sv */
`timescale 1ns/1ps
`include "cnn_conv_consts.svh"

module conv_assertions (
  input logic                     clock,
  input logic                     arst_n,
  input logic                     pixel_valid,
  input cnn_video_pkg::pix_beat_t pixel_in,
  input logic                     fm_valid,
  input cnn_conv_pkg::fm_beat_t   fm_out
);

  // assertion failures so far
  int fail_count = 0;

  // no output while in reset
  a_quiet_in_reset: assert property (@(posedge clock) !arst_n |-> !fm_valid)
    else begin
      $error("fm_valid high during reset");
      fail_count++;
    end

  // a pixel completing a window shows up 4 cycles later
  a_latency: assert property (@(posedge clock) disable iff (!arst_n)
    (pixel_valid && pixel_in.coord.x >= 2 && pixel_in.coord.y >= 2) |-> ##4 fm_valid)
    else begin
      $error("feature beat missing 4 cycles after a complete window");
      fail_count++;
    end

  // only complete-window positions come out
  a_coord_range: assert property (@(posedge clock) disable iff (!arst_n)
    fm_valid |-> (int'(fm_out.coord.x) >= `KSIZE - 1 && int'(fm_out.coord.y) >= `KSIZE - 1))
    else begin
      $error("feature coordinate outside the windowed area");
      fail_count++;
    end

endmodule

bind conv_top conv_assertions i_conv_assertions (.*);

/* testbench/tb_conv_top.sv */
`timescale 1ns/1ps
`include "cnn_conv_consts.svh"

module tb_conv_top;

  localparam int FRAME_PIX = `IMG_W * `IMG_H;
  localparam int NUM_PIX   = 2 * FRAME_PIX;
  localparam int COLS      = 3 + `NUM_KERNELS;
  // worst case 4 cycles per pixel plus reset and drain
  localparam int TIMEOUT_CYCLES = 2 * FRAME_PIX * 4 + 16 + 32;

  logic                     clock;
  logic                     arst_n;
  logic                     pixel_valid;
  cnn_video_pkg::pix_beat_t pixel_in;
  logic                     fm_valid;
  cnn_conv_pkg::fm_beat_t   fm_out;
  logic                     done;
  int                       error_count;
  int                       check_count;

  logic [15:0] golden [NUM_PIX*COLS];
  logic [15:0] lfsr_state;
  int          cycles;
  int          gap;
  int          total_errors;

  tb_clock_gen i_clock_gen (
    .clock (clock),
    .arst_n(arst_n)
  );

  conv_top i_conv_top (
    .clock      (clock),
    .arst_n     (arst_n),
    .pixel_valid(pixel_valid),
    .pixel_in   (pixel_in),
    .fm_valid   (fm_valid),
    .fm_out     (fm_out)
  );

  conv_checker i_conv_checker (
    .clock      (clock),
    .arst_n     (arst_n),
    .fm_valid   (fm_valid),
    .fm_out     (fm_out),
    .done       (done),
    .error_count(error_count),
    .check_count(check_count)
  );

  // 16 bit Fibonacci LFSR with taps 16 14 13 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    logic fb;
    fb = s[15] ^ s[13] ^ s[12] ^ s[10];
    return {s[14:0], fb};
  endfunction

  // two fresh bits give 0..3 idle cycles
  task automatic pick_gap(output int n);
    logic [1:0] bits;
    for (int b = 0; b < 2; b++) begin
      lfsr_state = lfsr_next(lfsr_state);
      bits[b]    = lfsr_state[0];
    end
    n = int'(bits);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    pixel_valid = 1'b0;
    pixel_in    = '0;
    lfsr_state  = 16'd3;
    $readmemh("testbench/conv_golden.txt", golden);
    @(posedge arst_n);
    for (int i = 0; i < NUM_PIX; i++) begin
      pick_gap(gap);
      repeat (gap) begin
        @(negedge clock);
        pixel_valid = 1'b0;
      end
      @(negedge clock);
      pixel_valid          = 1'b1;
      pixel_in.coord.x     = golden[i*COLS][`COORD_W-1:0];
      pixel_in.coord.y     = golden[i*COLS+1][`COORD_W-1:0];
      pixel_in.pixel       = golden[i*COLS+2][`PIX_W-1:0];
    end
    @(negedge clock);
    pixel_valid = 1'b0;
    while (!done) @(posedge clock);
    // let any stray beat reach the checker
    repeat (8) @(posedge clock);
    total_errors = error_count + i_conv_top.i_conv_assertions.fail_count;
    $display("errors=%0d checks=%0d", total_errors, check_count);
    if (total_errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

  // run limit
  initial begin
    cycles = 0;
    while (cycles < TIMEOUT_CYCLES) begin
      @(posedge clock);
      cycles++;
    end
    $display("timeout: outputs missing");
    total_errors = error_count + i_conv_top.i_conv_assertions.fail_count + 1;
    $display("errors=%0d checks=%0d", total_errors, check_count);
    $display("Testbench failed");
    $finish;
  end

endmodule

/* cnn_conv.f */
+incdir+include
design/cnn_video_pkg.sv
design/cnn_conv_pkg.sv
design/window_buffer.sv
design/mult_adder.sv
design/delay_line.sv
design/conv_top.sv
testbench/tb_clock_gen.sv
testbench/conv_checker.sv
testbench/conv_assertions.sv
testbench/tb_conv_top.sv

/* run_sim.sh */
#!/bin/sh
# build and run the conv_top testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
  -f cnn_conv.f \
  --top-module tb_conv_top \
  --Mdir obj_dir -o tb_conv_top

./obj_dir/tb_conv_top > sim.log 2>&1 || true
cat sim.log

if grep -q "Testbench failed" sim.log; then
  exit 1
fi
if ! grep -q "Testbench passed" sim.log; then
  echo "simulation ended without a result"
  exit 1
fi
exit 0

/* testbench/conv_golden.txt */
// columns: x y pixel k0 k1 k2 k3 (hex), kernels zero where no full window
// frame 0 pixel = x + 8y, frame 1 pixel = 200 - 3x - 16y
0 0 00 0 0 0 0
1 0 01 0 0 0 0
2 0 02 0 0 0 0
3 0 03 0 0 0 0
4 0 04 0 0 0 0
5 0 05 0 0 0 0
6 0 06 0 0 0 0
7 0 07 0 0 0 0
0 1 08 0 0 0 0
1 1 09 0 0 0 0
2 1 0a 0 0 0 0
3 1 0b 0 0 0 0
4 1 0c 0 0 0 0
5 1 0d 0 0 0 0
6 1 0e 0 0 0 0
7 1 0f 0 0 0 0
0 2 10 0 0 0 0
1 2 11 0 0 0 0
2 2 12 40 8 9 51
3 2 13 40 8 a 5a
4 2 14 40 8 b 63
5 2 15 40 8 c 6c
6 2 16 40 8 d 75
7 2 17 40 8 e 7e
0 3 18 0 0 0 0
1 3 19 0 0 0 0
2 3 1a 40 8 11 99
3 3 1b 40 8 12 a2
4 3 1c 40 8 13 ab
5 3 1d 40 8 14 b4
6 3 1e 40 8 15 bd
7 3 1f 40 8 16 c6
0 4 20 0 0 0 0
1 4 21 0 0 0 0
2 4 22 40 8 19 e1
3 4 23 40 8 1a ea
4 4 24 40 8 1b f3
5 4 25 40 8 1c fc
6 4 26 40 8 1d 105
7 4 27 40 8 1e 10e
0 5 28 0 0 0 0
1 5 29 0 0 0 0
2 5 2a 40 8 21 129
3 5 2b 40 8 22 132
4 5 2c 40 8 23 13b
5 5 2d 40 8 24 144
6 5 2e 40 8 25 14d
7 5 2f 40 8 26 156
0 6 30 0 0 0 0
1 6 31 0 0 0 0
2 6 32 40 8 29 171
3 6 33 40 8 2a 17a
4 6 34 40 8 2b 183
5 6 35 40 8 2c 18c
6 6 36 40 8 2d 195
7 6 37 40 8 2e 19e
0 7 38 0 0 0 0
1 7 39 0 0 0 0
2 7 3a 40 8 31 1b9
3 7 3b 40 8 32 1c2
4 7 3c 40 8 33 1cb
5 7 3d 40 8 34 1d4
6 7 3e 40 8 35 1dd
7 7 3f 40 8 36 1e6
0 0 c8 0 0 0 0
1 0 c5 0 0 0 0
2 0 c2 0 0 0 0
3 0 bf 0 0 0 0
4 0 bc 0 0 0 0
5 0 b9 0 0 0 0
6 0 b6 0 0 0 0
7 0 b3 0 0 0 0
0 1 b8 0 0 0 0
1 1 b5 0 0 0 0
2 1 b2 0 0 0 0
3 1 af 0 0 0 0
4 1 ac 0 0 0 0
5 1 a9 0 0 0 0
6 1 a6 0 0 0 0
7 1 a3 0 0 0 0
0 2 a8 0 0 0 0
1 2 a5 0 0 0 0
2 2 a2 0 0 b5 65d
3 2 9f 0 0 b2 642
4 2 9c 0 0 af 627
5 2 99 0 0 ac 60c
6 2 96 0 0 a9 5f1
7 2 93 0 0 a6 5d6
0 3 98 0 0 0 0
1 3 95 0 0 0 0
2 3 92 0 0 a5 5cd
3 3 8f 0 0 a2 5b2
4 3 8c 0 0 9f 597
5 3 89 0 0 9c 57c
6 3 86 0 0 99 561
7 3 83 0 0 96 546
0 4 88 0 0 0 0
1 4 85 0 0 0 0
2 4 82 0 0 95 53d
3 4 7f 0 0 92 522
4 4 7c 0 0 8f 507
5 4 79 0 0 8c 4ec
6 4 76 0 0 89 4d1
7 4 73 0 0 86 4b6
0 5 78 0 0 0 0
1 5 75 0 0 0 0
2 5 72 0 0 85 4ad
3 5 6f 0 0 82 492
4 5 6c 0 0 7f 477
5 5 69 0 0 7c 45c
6 5 66 0 0 79 441
7 5 63 0 0 76 426
0 6 68 0 0 0 0
1 6 65 0 0 0 0
2 6 62 0 0 75 41d
3 6 5f 0 0 72 402
4 6 5c 0 0 6f 3e7
5 6 59 0 0 6c 3cc
6 6 56 0 0 69 3b1
7 6 53 0 0 66 396
0 7 58 0 0 0 0
1 7 55 0 0 0 0
2 7 52 0 0 65 38d
3 7 4f 0 0 62 372
4 7 4c 0 0 5f 357
5 7 49 0 0 5c 33c
6 7 46 0 0 59 321
7 7 43 0 0 56 306
